/* design/mac_glue_pkg.sv */
package mac_glue_pkg;

  // ==========================================================================
  // Bus widths and types
  // ==========================================================================
  typedef logic [15:0] word_t;     // CPU data bus
  typedef logic [22:0] waddr_t;    // CPU byte address bits 23..1
  typedef logic [3:0]  via_idx_t;  // VIA register select, A12..A9

  // Memory depths, both mirror across their regions
  localparam int ROM_WORDS = 16;
  localparam int RAM_WORDS = 1024;

  // Region codes on A23..A20
  localparam logic [3:0] REGION_LOW = 4'h0;  // 0x0-0x3, only top two bits compared
  localparam logic [3:0] REGION_ROM = 4'h4;
  localparam logic [3:0] REGION_RAM = 4'h6;
  localparam logic [3:0] REGION_VIA = 4'hE;

  // ==========================================================================
  // VIA
  // ==========================================================================
  localparam via_idx_t VIA_T2_LO = 4'h8;
  localparam via_idx_t VIA_T2_HI = 4'h9;
  localparam via_idx_t VIA_SR    = 4'hA;
  localparam via_idx_t VIA_ACR   = 4'hB;
  localparam via_idx_t VIA_IFR   = 4'hD;
  localparam via_idx_t VIA_IER   = 4'hE;
  localparam via_idx_t VIA_PORTA = 4'hF;

  // IFR / IER bit positions
  localparam int INT_ONESEC   = 0;
  localparam int INT_VBLANK   = 1;
  localparam int INT_KEYREADY = 2;
  localparam int INT_T2       = 5;

  localparam logic [2:0] ACR_SR_OUT        = 3'b111;  // SR shift out, keyboard
  localparam logic [7:0] PORTA_RESET       = 8'h7F;
  localparam int         PORTA_OVERLAY_BIT = 4;       // Overlay while low
  localparam logic [7:0] VIA_LOW_BYTE      = 8'hEF;
  localparam logic [7:0] VIA_UNUSED        = 8'hBE;

  localparam int TIMER_DIV     = 32;  // Clocks per timer tick
  localparam int VSYNC_PER_SEC = 60;

endpackage

/* design/mac_bus_if.sv */
`timescale 1ns/1ps

interface mac_bus_if;
  import mac_glue_pkg::*;

  // Decoded access, driven by the bus controller
  logic   access;   // One cycle per bus cycle
  logic   we;
  waddr_t addr;
  logic   ube;      // Upper byte lane, D15..D8
  logic   lbe;      // Lower byte lane
  word_t  wdata;
  logic   via_cs;
  logic   ram_cs;
  logic   rom_cs;

  // Read data back, valid the edge after access
  logic [7:0] via_rdata;
  word_t      mem_rdata;

  modport ctrl (
    output access, we, addr, ube, lbe, wdata, via_cs, ram_cs, rom_cs,
    input  via_rdata, mem_rdata
  );

  modport via (
    input  access, we, addr, ube, wdata, via_cs,
    output via_rdata
  );

  modport mem (
    input  access, we, addr, ube, lbe, wdata, ram_cs, rom_cs,
    output mem_rdata
  );

endinterface

/* design/bus_ctrl.sv */
`timescale 1ns/1ps

module bus_ctrl (
  input  logic                clk_cpu,
  input  logic                reset,
  input  logic                req,
  input  logic                we,
  input  mac_glue_pkg::waddr_t addr,
  input  logic                ube,
  input  logic                lbe,
  input  mac_glue_pkg::word_t wdata,
  input  logic                overlaid,   // From VIA port A
  output logic                ack,
  output mac_glue_pkg::word_t rdata,
  mac_bus_if.ctrl             bus
);
  import mac_glue_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,    // access pulse out
    ST_RESPOND,   // slaves have data, capture and ack
    ST_RELEASE    // wait for req low
  } state_t;

  state_t     state;
  logic [3:0] region;
  logic       dec_via;
  logic       dec_ram;
  logic       dec_rom;
  logic       start;
  word_t      rd_mux;

  assign region = addr[22:19];  // A23..A20
  assign start  = (state == ST_IDLE) && req;

  // ==========================================================================
  // Address decode with boot overlay
  // ==========================================================================
  always_comb begin
    dec_via = 1'b0;
    dec_ram = 1'b0;
    dec_rom = 1'b0;
    if (region[3:2] == REGION_LOW[3:2]) begin
      dec_ram = overlaid;   // RAM at 0 once the overlay is on
      dec_rom = !overlaid;  // ROM at 0 out of reset
    end else begin
      case (region)
        REGION_ROM: dec_rom = 1'b1;
        REGION_RAM: dec_ram = !overlaid;  // Moves to 0 under overlay
        REGION_VIA: dec_via = 1'b1;
        default: ;                        // Unmapped, reads zero
      endcase
    end
  end

  // Read return, VIA sits on the upper byte only
  assign rd_mux = bus.via_cs ? {bus.via_rdata, VIA_LOW_BYTE} :
                  (bus.ram_cs || bus.rom_cs) ? bus.mem_rdata :
                  '0;

  // ==========================================================================
  // Four-phase handshake
  // ==========================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state      <= ST_IDLE;
      ack        <= 1'b0;
      bus.access <= 1'b0;
      bus.via_cs <= 1'b0;
      bus.ram_cs <= 1'b0;
      bus.rom_cs <= 1'b0;
    end else begin
      bus.access <= 1'b0;
      case (state)
        ST_IDLE: if (req) begin
          state      <= ST_ACCESS;
          bus.access <= 1'b1;
          bus.via_cs <= dec_via;  // Selects frozen for the whole cycle
          bus.ram_cs <= dec_ram;
          bus.rom_cs <= dec_rom;
        end
        ST_ACCESS:  state <= ST_RESPOND;
        ST_RESPOND: begin
          state <= ST_RELEASE;
          ack   <= 1'b1;
        end
        ST_RELEASE: if (!req) begin  // Ack held while master holds req
          state <= ST_IDLE;
          ack   <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request and read data registers
  always_ff @(posedge clk_cpu) begin
    if (start) begin
      bus.we    <= we;
      bus.addr  <= addr;
      bus.ube   <= ube;
      bus.lbe   <= lbe;
      bus.wdata <= wdata;
    end
    if (state == ST_RESPOND) rdata <= rd_mux;  // Stable until next cycle
  end

endmodule

/* design/via_regs.sv */
`timescale 1ns/1ps

module via_regs (
  input  logic       clk_cpu,
  input  logic       reset,
  input  logic       timer_strobe,
  input  logic       vblank_pulse,
  input  logic       onesec_pulse,
  output logic       overlaid,
  output logic       irq,
  output logic       kbd_out_strobe,
  output logic [7:0] kbd_out_data,
  mac_bus_if.via     bus
);
  import mac_glue_pkg::*;

  logic [7:0]  porta;
  logic [7:0]  acr;         // Auxiliary control
  logic [7:0]  sr;          // Shift register
  logic [6:0]  ifr;
  logic [6:0]  ier;
  logic [7:0]  t2_latch_lo;
  logic [15:0] t2_count;
  logic        t2_armed;
  logic [7:0]  din;
  logic [7:0]  rd_mux;
  logic        sel;
  logic        wr;
  logic        rd;
  logic        sr_out_wr;
  logic        any_int;
  via_idx_t    idx;

  // VIA lives on the upper byte lane
  assign sel       = bus.access && bus.via_cs && bus.ube;
  assign wr        = sel && bus.we;
  assign rd        = sel && !bus.we;
  assign idx       = bus.addr[11:8];  // A12..A9
  assign din       = bus.wdata[15:8];
  assign sr_out_wr = wr && (idx == VIA_SR) && (acr[4:2] == ACR_SR_OUT);

  assign any_int  = |(ifr & ier);
  assign irq      = any_int;
  assign overlaid = !porta[PORTA_OVERLAY_BIT];

  // ==========================================================================
  // Control registers, flags and timer 2
  // ==========================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      porta          <= PORTA_RESET;  // Overlay off
      acr            <= '0;
      ifr            <= '0;
      ier            <= '0;
      t2_count       <= '0;
      t2_armed       <= 1'b0;
      kbd_out_strobe <= 1'b0;
    end else begin
      kbd_out_strobe <= sr_out_wr;

      // Timer 2 counts down on divided ticks, one-shot
      if (timer_strobe && t2_armed) begin
        if (t2_count == '0) begin
          ifr[INT_T2] <= 1'b1;
          t2_armed    <= 1'b0;
        end else begin
          t2_count <= t2_count - 1'b1;
        end
      end

      if (wr) begin
        case (idx)
          VIA_T2_HI: begin  // Load and start
            t2_count    <= {din, t2_latch_lo};
            t2_armed    <= 1'b1;
            ifr[INT_T2] <= 1'b0;
          end
          VIA_SR:    if (acr[4:2] == ACR_SR_OUT) ifr[INT_KEYREADY] <= 1'b1;
          VIA_ACR:   acr <= din;
          VIA_IFR:   ifr <= ifr & ~din[6:0];  // Write one to clear
          VIA_IER:   if (din[7]) ier <= ier | din[6:0];
                     else ier <= ier & ~din[6:0];
          VIA_PORTA: porta <= din;
          default: ;
        endcase
      end else if (rd) begin
        // Read side effects on the flags
        case (idx)
          VIA_T2_LO: ifr[INT_T2] <= 1'b0;
          VIA_SR:    ifr[INT_KEYREADY] <= 1'b0;
          VIA_PORTA: begin
            ifr[INT_ONESEC] <= 1'b0;
            ifr[INT_VBLANK] <= 1'b0;
          end
          default: ;
        endcase
      end

      // Vsync events win over a same-cycle clear
      if (vblank_pulse) ifr[INT_VBLANK] <= 1'b1;
      if (onesec_pulse) ifr[INT_ONESEC] <= 1'b1;
    end
  end

  // ==========================================================================
  // Read mux and data registers
  // ==========================================================================
  always_comb begin
    case (idx)
      VIA_T2_LO: rd_mux = t2_count[7:0];
      VIA_T2_HI: rd_mux = t2_count[15:8];
      VIA_SR:    rd_mux = sr;
      VIA_ACR:   rd_mux = acr;
      VIA_IFR:   rd_mux = {any_int, ifr};   // Bit 7 is the IRQ summary
      VIA_IER:   rd_mux = {1'b0, ier};
      VIA_PORTA: rd_mux = {1'b0, porta[6:0]};
      default:   rd_mux = VIA_UNUSED;
    endcase
  end

  always_ff @(posedge clk_cpu) begin
    if (wr && idx == VIA_SR)    sr <= din;
    if (wr && idx == VIA_T2_LO) t2_latch_lo <= din;  // Latch only, count loads on HI
    if (sr_out_wr)              kbd_out_data <= din;  // Byte to keyboard
    if (rd)                     bus.via_rdata <= rd_mux;  // Pre-clear value returned
  end

endmodule

/* design/via_tick_gen.sv */
`timescale 1ns/1ps

module via_tick_gen (
  input  logic clk_cpu,
  input  logic reset,
  input  logic vsync,
  output logic timer_strobe,
  output logic vblank_pulse,
  output logic onesec_pulse
);
  import mac_glue_pkg::*;

  logic [$clog2(TIMER_DIV)-1:0] div;
  logic                         vsync_d;
  logic [5:0]                   sec_cnt;   // Vsyncs within the current second
  logic                         vsync_fall;

  assign vsync_fall = vsync_d && !vsync;

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      div          <= '0;
      vsync_d      <= 1'b0;  // No false edge if vsync starts high
      sec_cnt      <= '0;
      timer_strobe <= 1'b0;
      vblank_pulse <= 1'b0;
      onesec_pulse <= 1'b0;
    end else begin
      // Timer tick divider, free running
      div          <= (div == TIMER_DIV - 1) ? '0 : div + 1'b1;
      timer_strobe <= (div == TIMER_DIV - 1);

      vsync_d      <= vsync;
      vblank_pulse <= vsync_fall;
      onesec_pulse <= vsync_fall && (sec_cnt == 6'(VSYNC_PER_SEC - 1));
      if (vsync_fall) sec_cnt <= (sec_cnt == 6'(VSYNC_PER_SEC - 1)) ? '0 : sec_cnt + 1'b1;
    end
  end

endmodule

/* design/mac_memory.sv */
`timescale 1ns/1ps

module mac_memory (
  input  logic    clk_cpu,
  mac_bus_if.mem  bus
);
  import mac_glue_pkg::*;

  word_t rom [ROM_WORDS];
  word_t ram [RAM_WORDS];

  logic [$clog2(ROM_WORDS)-1:0] rom_idx;
  logic [$clog2(RAM_WORDS)-1:0] ram_idx;
  logic                         ram_wr;

  // Low address bits only so both images mirror
  assign rom_idx = bus.addr[$clog2(ROM_WORDS)-1:0];
  assign ram_idx = bus.addr[$clog2(RAM_WORDS)-1:0];
  assign ram_wr  = bus.access && bus.we && bus.ram_cs;

  // ROM image
  initial $readmemh("design/mac_rom.mem", rom);

  // ==========================================================================
  // RAM with byte lanes and synchronous read
  // ==========================================================================
  always_ff @(posedge clk_cpu) begin
    if (ram_wr && bus.ube) ram[ram_idx][15:8] <= bus.wdata[15:8];
    if (ram_wr && bus.lbe) ram[ram_idx][7:0]  <= bus.wdata[7:0];
  end

  // Read port shared by both returns old data on a write cycle
  always_ff @(posedge clk_cpu) begin
    if (bus.access) begin
      if (bus.ram_cs)      bus.mem_rdata <= ram[ram_idx];
      else if (bus.rom_cs) bus.mem_rdata <= rom[rom_idx];
    end
  end

endmodule

/* design/mac_glue_top.sv */
`timescale 1ns/1ps

module mac_glue_top (
  input  logic                 clk_cpu,
  input  logic                 reset,
  // CPU side bus, four-phase
  input  logic                 req,
  output logic                 ack,
  input  logic                 we,
  input  mac_glue_pkg::waddr_t addr,
  input  logic                 ube,
  input  logic                 lbe,
  input  mac_glue_pkg::word_t  wdata,
  output mac_glue_pkg::word_t  rdata,
  input  logic                 vsync,
  output logic                 irq,
  output logic                 kbd_out_strobe,
  output logic [7:0]           kbd_out_data
);

  logic overlaid;
  logic timer_strobe;
  logic vblank_pulse;
  logic onesec_pulse;

  mac_bus_if bus_if ();

  // ==========================================================================
  // Bus front end
  // ==========================================================================
  bus_ctrl u_bus_ctrl (
    .clk_cpu  (clk_cpu),
    .reset    (reset),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .ube      (ube),
    .lbe      (lbe),
    .wdata    (wdata),
    .overlaid (overlaid),
    .ack      (ack),
    .rdata    (rdata),
    .bus      (bus_if.ctrl)
  );

  mac_memory u_mem (
    .clk_cpu (clk_cpu),
    .bus     (bus_if.mem)
  );

  // ==========================================================================
  // VIA and its tick sources
  // ==========================================================================
  via_tick_gen u_ticks (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .vsync        (vsync),
    .timer_strobe (timer_strobe),
    .vblank_pulse (vblank_pulse),
    .onesec_pulse (onesec_pulse)
  );

  via_regs u_via (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .timer_strobe   (timer_strobe),
    .vblank_pulse   (vblank_pulse),
    .onesec_pulse   (onesec_pulse),
    .overlaid       (overlaid),
    .irq            (irq),
    .kbd_out_strobe (kbd_out_strobe),
    .kbd_out_data   (kbd_out_data),
    .bus            (bus_if.via)
  );

endmodule

/* tb/tb_mac_glue.sv */
`timescale 1ns/1ps

module tb_mac_glue;
  import mac_glue_pkg::*;

  localparam int BUS_TIMEOUT = 50;   // Clocks per handshake phase
  localparam int IRQ_TIMEOUT = 100;

  logic       clk_cpu;
  logic       reset;
  logic       req;
  logic       ack;
  logic       we;
  waddr_t     addr;
  logic       ube;
  logic       lbe;
  word_t      wdata;
  word_t      rdata;
  logic       vsync;
  logic       irq;
  logic       kbd_out_strobe;
  logic [7:0] kbd_out_data;

  word_t       rom_model [ROM_WORDS];   // Same image the DUT loads
  logic [31:0] lcg_state;
  int          value_errors;
  int          protocol_errors;
  int          timeouts;
  int          strobe_count;            // Keyboard strobe cycles seen
  logic [7:0]  strobe_data;
  longint      cycle;

  mac_glue_top u_dut (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .req            (req),
    .ack            (ack),
    .we             (we),
    .addr           (addr),
    .ube            (ube),
    .lbe            (lbe),
    .wdata          (wdata),
    .rdata          (rdata),
    .vsync          (vsync),
    .irq            (irq),
    .kbd_out_strobe (kbd_out_strobe),
    .kbd_out_data   (kbd_out_data)
  );

  initial clk_cpu = 1'b0;
  always #4 clk_cpu = ~clk_cpu;  // 8 ns period

  always @(posedge clk_cpu) begin
    cycle <= cycle + 1;
    if (kbd_out_strobe) begin
      strobe_count <= strobe_count + 1;
      strobe_data  <= kbd_out_data;  // Byte seen with the strobe
    end
  end

  // ==========================================================================
  // Protocol assertions
  // ==========================================================================
  property ack_rises_with_req;
    @(posedge clk_cpu) disable iff (reset) $rose(ack) |-> $past(req);
  endproperty

  property ack_falls_after_req;
    @(posedge clk_cpu) disable iff (reset) $fell(ack) |-> !$past(req);
  endproperty

  property strobe_one_cycle;
    @(posedge clk_cpu) disable iff (reset) kbd_out_strobe |=> !kbd_out_strobe;
  endproperty

  a_ack_rise: assert property (ack_rises_with_req)
    else begin
      $display("Protocol violation at t=%0t: ack rose while req was low", $time);
      protocol_errors++;
    end

  a_ack_fall: assert property (ack_falls_after_req)
    else begin
      $display("Protocol violation at t=%0t: ack fell while req was still high", $time);
      protocol_errors++;
    end

  a_strobe: assert property (strobe_one_cycle)
    else begin
      $display("Protocol violation at t=%0t: kbd_out_strobe longer than a cycle", $time);
      protocol_errors++;
    end

  // ==========================================================================
  // Helpers
  // ==========================================================================
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return lcg_state;
  endfunction

  // VIA register idx at 0xEFE1FE plus idx times 0x200
  function automatic logic [23:0] via_byte_addr(input via_idx_t idx);
    return {4'hE, 7'h7F, idx, 9'h1FE};
  endfunction

  task automatic check_equal(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected)
      else begin
        $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        value_errors++;
      end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected)
      else begin
        $display("ERROR t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
        value_errors++;
      end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at t=%0t while waiting for %s", $time, what);
    timeouts++;
  endtask

  // Four-phase master, inputs change on the falling edge only
  task automatic bus_cycle(input logic write, input logic [23:0] byte_addr,
                           input logic upper, input logic lower,
                           input word_t data, output word_t result);
    int n;
    n = 0;
    while (ack && n < BUS_TIMEOUT) begin  // Previous cycle fully released
      @(negedge clk_cpu);
      n++;
    end
    if (ack) report_timeout("ack low before a new request");
    req   = 1'b1;
    we    = write;
    addr  = byte_addr[23:1];
    ube   = upper;
    lbe   = lower;
    wdata = data;
    n = 0;
    do begin
      @(negedge clk_cpu);
      n++;
    end while (!ack && n < BUS_TIMEOUT);
    if (!ack) report_timeout("ack to rise");
    result = rdata;  // Valid while ack is high
    req    = 1'b0;
    n = 0;
    do begin
      @(negedge clk_cpu);
      n++;
    end while (ack && n < BUS_TIMEOUT);
    if (ack) report_timeout("ack to fall");
  endtask

  task automatic bus_write(input logic [23:0] byte_addr, input logic upper,
                           input logic lower, input word_t data);
    word_t unused;
    bus_cycle(1'b1, byte_addr, upper, lower, data, unused);
  endtask

  task automatic bus_read(input logic [23:0] byte_addr, output word_t result);
    bus_cycle(1'b0, byte_addr, 1'b1, 1'b1, 16'h0000, result);
  endtask

  task automatic via_write(input via_idx_t idx, input logic [7:0] value);
    bus_write(via_byte_addr(idx), 1'b1, 1'b0, {value, 8'h00});  // Upper lane only
  endtask

  task automatic via_read(input via_idx_t idx, output logic [7:0] value);
    word_t rd;
    bus_read(via_byte_addr(idx), rd);
    value = rd[15:8];
  endtask

  task automatic via_check(input via_idx_t idx, input logic [7:0] expected,
                           input string name);
    word_t rd;
    bus_read(via_byte_addr(idx), rd);
    check_equal(name, {expected, VIA_LOW_BYTE}, rd);
  endtask

  task automatic wait_irq(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (irq !== level && n < limit) begin
      @(negedge clk_cpu);
      n++;
    end
    if (irq !== level) report_timeout(what);
  endtask

  task automatic vsync_fall();
    vsync = 1'b1;
    repeat (3) @(negedge clk_cpu);
    vsync = 1'b0;                   // Edge seen on the next rising clock
    repeat (3) @(negedge clk_cpu);
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin : stimulus
    word_t       rd;
    word_t       ram_data;
    word_t       upd_data;
    logic [31:0] rnd;
    logic [9:0]  ram_ofs;
    logic [15:0] rom_ofs;
    logic [7:0]  kbd_byte;
    logic [7:0]  via_byte;
    logic [15:0] t2_count;
    logic [6:0]  ier_model;
    logic [6:0]  ifr_model;
    logic [7:0]  ier_write;
    int          strobes_before;
    longint      start;

    lcg_state       = 32'h5cd85edd;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    strobe_count    = 0;
    cycle           = 0;
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    ube   = 1'b0;
    lbe   = 1'b0;
    wdata = '0;
    vsync = 1'b0;
    $readmemh("design/mac_rom.mem", rom_model);
    repeat (5) @(negedge clk_cpu);  // Five rising edges in reset
    reset = 1'b0;

    // Reset state
    check_bit("ack", 1'b0, ack);
    check_bit("irq", 1'b0, irq);
    check_bit("kbd_out_strobe", 1'b0, kbd_out_strobe);
    via_check(VIA_PORTA, 8'h7F, "rdata port A after reset");
    bus_read(24'h800000, rd);
    check_equal("rdata unmapped", 16'h0000, rd);

    // RAM in region 6 with byte lanes
    rnd      = next_random();
    ram_ofs  = rnd[9:0];
    ram_data = rnd[31:16];
    bus_write({4'h6, 9'h000, ram_ofs, 1'b0}, 1'b1, 1'b1, ram_data);
    bus_read({4'h6, 9'h000, ram_ofs, 1'b0}, rd);
    check_equal("rdata RAM", ram_data, rd);
    rnd      = next_random();
    upd_data = rnd[15:0];
    bus_write({4'h6, 9'h000, ram_ofs, 1'b0}, 1'b1, 1'b0, upd_data);
    ram_data = {upd_data[15:8], ram_data[7:0]};  // Lower byte kept
    bus_read({4'h6, 9'h000, ram_ofs, 1'b0}, rd);
    check_equal("rdata RAM upper lane", ram_data, rd);

    // ROM in region 4 mirrors every 16 words
    repeat (4) begin
      rnd     = next_random();
      rom_ofs = rnd[15:0];
      bus_read({4'h4, 3'b000, rom_ofs, 1'b0}, rd);
      check_equal("rdata ROM", rom_model[rom_ofs[3:0]], rd);
    end

    // Overlay on, RAM moves down to 0
    via_write(VIA_PORTA, 8'h6F);
    bus_read({4'h0, 9'h000, ram_ofs, 1'b0}, rd);
    check_equal("rdata RAM at 0 under overlay", ram_data, rd);
    bus_read({4'h6, 9'h000, ram_ofs, 1'b0}, rd);
    check_equal("rdata region 6 under overlay", 16'h0000, rd);
    via_write(VIA_PORTA, 8'h7F);
    bus_read({4'h0, 9'h000, ram_ofs, 1'b0}, rd);
    check_equal("rdata ROM at 0", rom_model[ram_ofs[3:0]], rd);

    // Vblank and one-second flags
    via_write(VIA_IER, 8'h82);
    vsync_fall();                          // Fall 1
    wait_irq(1'b1, IRQ_TIMEOUT, "irq from vblank");
    via_check(VIA_IFR, 8'h82, "IFR after vblank");
    via_check(VIA_PORTA, 8'h7F, "rdata port A");
    check_bit("irq after port A read", 1'b0, irq);
    via_check(VIA_IFR, 8'h00, "IFR after port A read");
    repeat (58) vsync_fall();              // Falls 2 to 59
    via_check(VIA_IFR, 8'h82, "IFR before 60th vsync");
    via_check(VIA_PORTA, 8'h7F, "rdata port A");
    vsync_fall();                          // Fall 60
    wait_irq(1'b1, IRQ_TIMEOUT, "irq from 60th vsync");
    via_check(VIA_IFR, 8'h83, "IFR after 60th vsync");
    via_check(VIA_PORTA, 8'h7F, "rdata port A");
    via_write(VIA_IER, 8'h02);
    via_check(VIA_IFR, 8'h00, "IFR after clears");

    // Timer 2 polled with its enable off
    rnd      = next_random();
    t2_count = {12'h000, rnd[3:0]} + 16'd1;
    via_write(VIA_T2_LO, t2_count[7:0]);
    via_write(VIA_T2_HI, t2_count[15:8]);
    start    = cycle;
    via_byte = 8'h00;
    while (!via_byte[INT_T2] && (cycle - start) < (t2_count + 2) * TIMER_DIV) begin
      via_read(VIA_IFR, via_byte);
    end
    if (!via_byte[INT_T2]) report_timeout("IFR bit 5 from timer 2");
    check_equal("IFR timer 2 masked", 16'h0020, {8'h00, via_byte});
    check_bit("irq with T2 masked", 1'b0, irq);
    via_write(VIA_IER, 8'hA0);
    check_bit("irq with T2 enabled", 1'b1, irq);
    via_read(VIA_T2_LO, via_byte);         // Clears the flag
    check_bit("irq after T2 low read", 1'b0, irq);
    via_check(VIA_IFR, 8'h00, "IFR after T2 low read");

    // Timer 2 again with irq enabled
    via_write(VIA_T2_LO, t2_count[7:0]);
    via_write(VIA_T2_HI, t2_count[15:8]);
    wait_irq(1'b1, (t2_count + 2) * TIMER_DIV, "irq from timer 2");
    via_check(VIA_IFR, 8'hA0, "IFR timer 2 enabled");
    via_read(VIA_T2_LO, via_byte);
    check_bit("irq after T2 low read", 1'b0, irq);
    via_write(VIA_IER, 8'h20);

    // Keyboard-out shift register
    via_write(VIA_ACR, 8'h1C);             // SR mode 111
    rnd            = next_random();
    kbd_byte       = rnd[7:0];
    strobes_before = strobe_count;
    via_write(VIA_SR, kbd_byte);
    check_equal("kbd_out_strobe pulses", 16'd1, 16'(strobe_count - strobes_before));
    check_equal("kbd_out_data at strobe", {8'h00, kbd_byte}, {8'h00, strobe_data});
    check_equal("kbd_out_data", {8'h00, kbd_byte}, {8'h00, kbd_out_data});
    via_check(VIA_IFR, 8'h04, "IFR after SR write");
    via_check(VIA_SR, kbd_byte, "rdata SR");
    via_check(VIA_IFR, 8'h00, "IFR after SR read");
    via_write(VIA_ACR, 8'h00);
    strobes_before = strobe_count;
    via_write(VIA_SR, rnd[15:8]);
    check_equal("kbd_out_strobe pulses ACR 0", 16'd0, 16'(strobe_count - strobes_before));
    via_check(VIA_IFR, 8'h00, "IFR after SR write ACR 0");

    // IER set and clear against two pending flags
    vsync_fall();
    via_write(VIA_ACR, 8'h1C);
    via_write(VIA_SR, 8'h5A);
    via_write(VIA_ACR, 8'h00);
    ifr_model = 7'b0000110;                // Vblank and keyready
    ier_model = 7'b0000000;
    via_check(VIA_IFR, 8'h06, "IFR pending flags");
    repeat (12) begin
      rnd       = next_random();
      ier_write = rnd[7:0];
      if (ier_write[7]) ier_model = ier_model | ier_write[6:0];
      else ier_model = ier_model & ~ier_write[6:0];
      via_write(VIA_IER, ier_write);
      via_check(VIA_IER, {1'b0, ier_model}, "rdata IER");
      check_bit("irq", |(ifr_model & ier_model), irq);
      via_check(VIA_IFR, {|(ifr_model & ier_model), ifr_model}, "rdata IFR");
    end

    $display("Closing report: value errors %0d, protocol errors %0d, timeouts %0d",
             value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* design/mac_rom.mem */
// One 16-bit ROM word per line in hex, word index 0 at the top
4AFC
0000
4E71
6000
1234
A5C3
0F0F
F00D
8001
7E55
C0DE
2468
9BDF
3C3C
E1E1
5A96

/* mac_glue.f */
design/mac_glue_pkg.sv
design/mac_bus_if.sv
design/bus_ctrl.sv
design/via_regs.sv
design/via_tick_gen.sv
design/mac_memory.sv
design/mac_glue_top.sv
tb/tb_mac_glue.sv

/* Bender.yml */
package:
  name: mac_glue

sources:
  - design/mac_glue_pkg.sv
  - design/mac_bus_if.sv
  - design/bus_ctrl.sv
  - design/via_regs.sv
  - design/via_tick_gen.sv
  - design/mac_memory.sv
  - design/mac_glue_top.sv
  - target: test
    files:
      - tb/tb_mac_glue.sv
